// File: rtl/hit_if.sv
`timescale 1ns/1ps

// hit and region flags, execute to result
interface hit_if;

    logic                valid;
    render_pkg::region_t region;
    logic                self_hit;     // inside the fixed centre box
    logic                enemy_hit;
    logic                out_of_map;   // main view only
    logic                p1_dot;       // minimap only
    logic                p2_dot;

    modport execute_mp (
        output valid, region, self_hit, enemy_hit, out_of_map, p1_dot, p2_dot
    );

    modport result_mp (
        input valid, region, self_hit, enemy_hit, out_of_map, p1_dot, p2_dot
    );

endinterface

// File: rtl/pixel_decode.sv
`timescale 1ns/1ps
`include "render_params.svh"

module pixel_decode (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req,
    input  render_pkg::coord_t h_cnt,
    input  render_pkg::coord_t v_cnt,
    input  render_pkg::coord_t p1_x,
    input  render_pkg::coord_t p1_y,
    input  render_pkg::coord_t p2_x,
    input  render_pkg::coord_t p2_y,
    input  logic               busy,        // result side still owns a pixel
    view_if.decode_mp          view
);

    logic                   active;         // set from capture until the pixel retires
    logic                   start;
    render_pkg::region_t    cls;
    render_pkg::world_pos_t p1_pos;
    render_pkg::world_pos_t p2_pos;

    assign start  = req && !busy && !active;
    assign p1_pos = '{x: p1_x, y: p1_y};
    assign p2_pos = '{x: p2_x, y: p2_y};

    // --------------------
    // classify
    // --------------------
    always_comb begin
        cls.blank      = (h_cnt >= `RND_H_VISIBLE) || (v_cnt >= `RND_V_VISIBLE);
        cls.hud_sep    = (v_cnt == `RND_HUD_TOP - 10'd1) || (v_cnt == `RND_HUD_TOP);
        cls.hud        = (v_cnt >= `RND_HUD_TOP);
        cls.minimap    = (h_cnt >= `RND_MM_X0) && (h_cnt < `RND_MM_X1) && cls.hud;
        cls.screen_sep = (h_cnt == `RND_HALF_W - 10'd1) || (h_cnt == `RND_HALF_W);
        cls.is_right   = (h_cnt >= `RND_HALF_W);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            view.valid <= 1'b0;
        end else begin
            view.valid <= start;
            if (start)
                active <= 1'b1;
            else if (!busy && !view.valid)  // handed over and acked
                active <= 1'b0;
        end
    end

    // payload, picked up only on capture
    always_ff @(posedge clk) begin
        if (start) begin
            view.region    <= cls;
            view.h         <= h_cnt;
            view.v         <= v_cnt;
            view.rel_x     <= cls.is_right ? h_cnt - `RND_HALF_W : h_cnt;
            view.self_pos  <= cls.is_right ? p2_pos : p1_pos;
            view.enemy_pos <= cls.is_right ? p1_pos : p2_pos;
        end
    end

endmodule

// File: rtl/pixel_execute.sv
`timescale 1ns/1ps
`include "render_params.svh"

module pixel_execute (
    input  logic                  clk,
    input  logic                  arst_n,
    view_if.execute_mp            view,
    hit_if.execute_mp             hit,
    output logic                  map_rd,
    output render_pkg::map_addr_t map_addr
);

    // row major address with 320 = 256 + 64
    function automatic render_pkg::map_addr_t lin_addr(render_pkg::coord_t x,
                                                       render_pkg::coord_t y);
        render_pkg::map_addr_t ye;
        ye = {7'd0, y};
        return (ye << 8) + (ye << 6) + {7'd0, x};
    endfunction

    function automatic logic near(render_pkg::coord_t a, render_pkg::coord_t b);
        render_pkg::coord_t d;
        d = (a >= b) ? a - b : b - a;
        return d <= `RND_DOT_R;
    endfunction

    // --------------------
    // main view
    // --------------------
    render_pkg::coord_t wx, wy;
    logic               out_of_map;
    logic               in_view;

    assign wx = (view.rel_x >> `RND_ZOOM_SHIFT) + (view.self_pos.x - `RND_VIEW_OFS_X);
    assign wy = (view.v >> `RND_ZOOM_SHIFT) + (view.self_pos.y - `RND_VIEW_OFS_Y);
    assign out_of_map = (wx >= `RND_MAP_W) || (wy >= `RND_MAP_H);
    assign in_view = !view.region.blank && !view.region.hud && !view.region.hud_sep;

    // minimap read coords in world units
    render_pkg::coord_t     mm_x, mm_y;
    render_pkg::world_pos_t p1_pos, p2_pos;

    assign mm_x   = (view.h - `RND_MM_X0) << `RND_MM_SHIFT;
    assign mm_y   = (view.v - `RND_HUD_TOP) << `RND_MM_SHIFT;
    assign p1_pos = view.region.is_right ? view.enemy_pos : view.self_pos;
    assign p2_pos = view.region.is_right ? view.self_pos : view.enemy_pos;

    // --------------------
    // car boxes
    // --------------------
    logic               self_hit;
    logic               enemy_hit;
    logic signed [15:0] dx, dy, ex_lo, ex_hi, ey_lo, ey_hi, px, py;

    assign self_hit = (view.rel_x >= `RND_SELF_CX - `RND_CAR_HALF) &&
                      (view.rel_x <= `RND_SELF_CX + `RND_CAR_HALF) &&
                      (view.v >= `RND_SELF_CY - `RND_CAR_HALF) &&
                      (view.v <= `RND_SELF_CY + `RND_CAR_HALF);

    assign dx = $signed({6'd0, view.enemy_pos.x}) - $signed({6'd0, view.self_pos.x});
    assign dy = $signed({6'd0, view.enemy_pos.y}) - $signed({6'd0, view.self_pos.y});

    // enemy box edges around the zoomed position difference
    assign ex_lo = $signed({6'd0, `RND_SELF_CX - `RND_CAR_HALF}) + (dx <<< `RND_ZOOM_SHIFT);
    assign ex_hi = $signed({6'd0, `RND_SELF_CX + `RND_CAR_HALF}) + (dx <<< `RND_ZOOM_SHIFT);
    assign ey_lo = $signed({6'd0, `RND_SELF_CY - `RND_CAR_HALF}) + (dy <<< `RND_ZOOM_SHIFT);
    assign ey_hi = $signed({6'd0, `RND_SELF_CY + `RND_CAR_HALF}) + (dy <<< `RND_ZOOM_SHIFT);
    assign px    = $signed({6'd0, view.rel_x});
    assign py    = $signed({6'd0, view.v});

    assign enemy_hit = (px >= ex_lo) && (px <= ex_hi) &&
                       (py >= ey_lo) && (py <= ey_hi);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit.valid <= 1'b0;
            map_rd    <= 1'b0;
        end else begin
            hit.valid <= view.valid;
            map_rd    <= view.valid && !view.region.blank;    // single read pulse
        end
    end

    always_ff @(posedge clk) begin
        if (view.valid) begin
            hit.region     <= view.region;
            hit.self_hit   <= self_hit;
            hit.enemy_hit  <= enemy_hit;
            hit.out_of_map <= out_of_map;
            hit.p1_dot     <= near(mm_x, p1_pos.x) && near(mm_y, p1_pos.y);
            hit.p2_dot     <= near(mm_x, p2_pos.x) && near(mm_y, p2_pos.y);
            if (in_view && !out_of_map)
                map_addr <= lin_addr(wx, wy);
            else if (view.region.minimap)
                map_addr <= lin_addr(mm_x, mm_y);
            else
                map_addr <= '0;
        end
    end

endmodule

// File: rtl/pixel_result.sv
`timescale 1ns/1ps
`include "render_params.svh"

module pixel_result (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  render_pkg::map_index_t map_index,
    hit_if.result_mp               hit,
    output logic                   ack,
    output logic [3:0]             red,
    output logic [3:0]             green,
    output logic [3:0]             blue,
    output logic                   busy
);

    // map colour indices
    function automatic render_pkg::rgb12_t palette(render_pkg::map_index_t idx);
        case (idx)
            4'd0:    return `RND_COL_OUT;   // grass
            4'd1:    return 12'h888;
            4'd2:    return 12'hFFF;
            4'd3:    return 12'hF80;
            4'd4:    return 12'h00A;
            4'd5:    return 12'h642;
            default: return 12'h000;
        endcase
    endfunction

    logic                pend;              // waiting on map_index
    render_pkg::region_t rg;
    logic                self_q, enemy_q, oom_q, p1_q, p2_q;
    render_pkg::rgb12_t  pix;
    render_pkg::rgb12_t  colour;

    // held while the memory answers
    always_ff @(posedge clk) begin
        if (hit.valid) begin
            rg      <= hit.region;
            self_q  <= hit.self_hit;
            enemy_q <= hit.enemy_hit;
            oom_q   <= hit.out_of_map;
            p1_q    <= hit.p1_dot;
            p2_q    <= hit.p2_dot;
        end
    end

    // --------------------
    // colour priority
    // --------------------
    always_comb begin
        if (rg.blank)
            pix = 12'h000;
        else if (rg.hud_sep)
            pix = `RND_COL_SEP;
        else if (rg.hud) begin
            if (rg.minimap && p1_q)
                pix = `RND_COL_P1;
            else if (rg.minimap && p2_q)
                pix = `RND_COL_P2;
            else if (rg.minimap)
                pix = palette(map_index);
            else
                pix = `RND_COL_HUD;
        end else if (rg.screen_sep)
            pix = `RND_COL_SEP;
        else if (self_q)
            pix = rg.is_right ? `RND_COL_P2 : `RND_COL_P1;     // own car
        else if (enemy_q)
            pix = rg.is_right ? `RND_COL_P1 : `RND_COL_P2;
        else if (oom_q)
            pix = `RND_COL_OUT;
        else
            pix = palette(map_index);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend   <= 1'b0;
            ack    <= 1'b0;
            colour <= '0;
        end else begin
            pend <= hit.valid;
            if (pend) begin
                colour <= pix;
                ack    <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;    // requester let go
            end
        end
    end

    assign busy  = hit.valid || pend || ack;
    assign red   = colour.r;
    assign green = colour.g;
    assign blue  = colour.b;

endmodule

// File: rtl/render_params.svh
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// --------------------
// screen geometry
// --------------------
`define RND_H_VISIBLE   10'd640
`define RND_V_VISIBLE   10'd480
`define RND_HALF_W      10'd320     // first column of the player 2 view
`define RND_HUD_TOP     10'd360     // first HUD row

// map size in world units
`define RND_MAP_W       10'd320
`define RND_MAP_H       10'd240

// main view zoom, screen to world is a right shift
`define RND_ZOOM_SHIFT  3
`define RND_VIEW_OFS_X  10'd20      // world offset of the view's left edge
`define RND_VIEW_OFS_Y  10'd22

// self car sits fixed at this view position
`define RND_SELF_CX     10'd160
`define RND_SELF_CY     10'd180
`define RND_CAR_HALF    10'd37      // box spans centre +- this

// --------------------
// minimap window
// --------------------
`define RND_MM_X0       10'd240
`define RND_MM_X1       10'd400     // exclusive
`define RND_MM_SHIFT    1           // half scale
`define RND_DOT_R       10'd4       // dot half size in world units

// fixed colours
`define RND_COL_SEP     12'hFFF
`define RND_COL_HUD     12'h444
`define RND_COL_OUT     12'h6B4
`define RND_COL_P1      12'hF00
`define RND_COL_P2      12'h00F

`endif

// File: rtl/render_pkg.sv
package render_pkg;

    // screen or world coordinate
    typedef logic [9:0] coord_t;

    // one player's place on the map
    typedef struct packed {
        coord_t x;
        coord_t y;
    } world_pos_t;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    // map memory word and address
    typedef logic [3:0]  map_index_t;
    typedef logic [16:0] map_addr_t;    // 320 x 240 words

    // --------------------
    // pixel class flags
    // --------------------
    // several may be set at once, result sorts them by priority
    typedef struct packed {
        logic blank;        // outside the visible area
        logic hud_sep;      // rows 359 and 360
        logic hud;          // bottom HUD strip
        logic minimap;      // minimap window inside the HUD
        logic screen_sep;   // columns 319 and 320
        logic is_right;     // player 2 half
    } region_t;

endpackage

// File: rtl/split_screen_renderer.sv
`timescale 1ns/1ps

module split_screen_renderer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  render_pkg::coord_t     h_cnt,
    input  render_pkg::coord_t     v_cnt,
    input  render_pkg::coord_t     p1_x,
    input  render_pkg::coord_t     p1_y,
    input  render_pkg::coord_t     p2_x,
    input  render_pkg::coord_t     p2_y,
    input  render_pkg::map_index_t map_index,
    output logic                   ack,
    output logic [3:0]             red,
    output logic [3:0]             green,
    output logic [3:0]             blue,
    output logic                   map_rd,
    output render_pkg::map_addr_t  map_addr
);

    logic busy;     // result still holds a pixel

    view_if view_bus ();
    hit_if  hit_bus ();

    // --------------------
    // stages
    // --------------------
    pixel_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .h_cnt  (h_cnt),
        .v_cnt  (v_cnt),
        .p1_x   (p1_x),
        .p1_y   (p1_y),
        .p2_x   (p2_x),
        .p2_y   (p2_y),
        .busy   (busy),
        .view   (view_bus.decode_mp)
    );

    pixel_execute u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .view     (view_bus.execute_mp),
        .hit      (hit_bus.execute_mp),
        .map_rd   (map_rd),
        .map_addr (map_addr)    // external map memory
    );

    pixel_result u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .map_index (map_index),
        .hit       (hit_bus.result_mp),
        .ack       (ack),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .busy      (busy)
    );

endmodule

// File: rtl/view_if.sv
`timescale 1ns/1ps

// classified pixel, decode to execute
interface view_if;

    logic                   valid;      // one cycle per pixel
    render_pkg::region_t    region;
    render_pkg::coord_t     rel_x;      // column within the half
    render_pkg::coord_t     v;
    render_pkg::coord_t     h;
    render_pkg::world_pos_t self_pos;   // player that owns this half
    render_pkg::world_pos_t enemy_pos;

    modport decode_mp (
        output valid, region, rel_x, v, h, self_pos, enemy_pos
    );

    modport execute_mp (
        input valid, region, rel_x, v, h, self_pos, enemy_pos
    );

endinterface

// File: src.f
+incdir+rtl
rtl/render_pkg.sv
rtl/view_if.sv
rtl/hit_if.sv
rtl/pixel_decode.sv
rtl/pixel_execute.sv
rtl/pixel_result.sv
rtl/split_screen_renderer.sv
tb/tb_split_screen_renderer.sv

// File: tb/tb_split_screen_renderer.sv
`timescale 1ns/1ps
`include "render_params.svh"

module tb_split_screen_renderer;

    localparam int CLK_PERIOD      = 8;
    localparam int ACK_LIMIT       = 16;                      // cycles before a query gives up
    localparam int QUERY_COUNT     = 70;
    localparam int WATCHDOG_CYCLES = QUERY_COUNT * 20 + 200;

    logic                   clk;
    logic                   arst_n;
    logic                   req;
    logic [9:0]             h_cnt, v_cnt;
    logic [9:0]             p1_x, p1_y, p2_x, p2_y;
    render_pkg::map_index_t map_index;
    logic                   ack;
    logic [3:0]             red, green, blue;
    logic                   map_rd;
    render_pkg::map_addr_t  map_addr;

    int          errors = 0;
    int unsigned rng_state = 88;
    int                     reads = 0;      // map reads in the current query
    render_pkg::map_addr_t  last_addr;

    split_screen_renderer UUT (
        .clk(clk), .arst_n(arst_n), .req(req), .h_cnt(h_cnt), .v_cnt(v_cnt),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y), .map_index(map_index),
        .ack(ack), .red(red), .green(green), .blue(blue),
        .map_rd(map_rd), .map_addr(map_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // map memory model with a one cycle read
    always @(posedge clk) begin
        if (map_rd) begin
            map_index <= 4'(map_addr % 17'd6);
            last_addr <= map_addr;
            reads     <= reads + 1;
        end
    end

    // --------------------
    // reference helpers
    // --------------------
    function automatic int rand_range(int lo, int hi);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return lo + int'(rng_state[30:16]) % (hi - lo + 1);
    endfunction

    function automatic logic [11:0] map_palette(int idx);
        case (idx)
            0:       return 12'h6B4;
            1:       return 12'h888;
            2:       return 12'hFFF;
            3:       return 12'hF80;
            4:       return 12'h00A;
            5:       return 12'h642;
            default: return 12'h000;
        endcase
    endfunction

    // true when the pixel falls in the self or enemy box of its half
    function automatic bit in_car_box(int h, int v, int p1x, int p1y, int p2x, int p2y);
        int rel, sx, sy, ex, ey, cx, cy, hw, ecx, ecy;
        bit right;
        right = h >= 320;
        rel = right ? h - 320 : h;
        sx = right ? p2x : p1x;
        sy = right ? p2y : p1y;
        ex = right ? p1x : p2x;
        ey = right ? p1y : p2y;
        cx = `RND_SELF_CX;
        cy = `RND_SELF_CY;
        hw = `RND_CAR_HALF;
        ecx = cx + (ex - sx) * 8;     // zoom of 8
        ecy = cy + (ey - sy) * 8;
        return (rel >= cx - hw && rel <= cx + hw && v >= cy - hw && v <= cy + hw) ||
               (rel >= ecx - hw && rel <= ecx + hw && v >= ecy - hw && v <= ecy + hw);
    endfunction

    // plain map pixel of the main view
    function automatic logic [11:0] view_colour(int h, int v, int p1x, int p1y,
                                                int p2x, int p2y);
        int rel, wx, wy;
        rel = (h >= 320) ? h - 320 : h;
        wx = rel / 8 + ((h >= 320) ? p2x : p1x) - 20;
        wy = v / 8 + ((h >= 320) ? p2y : p1y) - 22;
        if (wx >= 320 || wy >= 240)
            return 12'h6B4;
        return map_palette((wy * 320 + wx) % 6);
    endfunction

    // map address of a main view pixel, 0 when it falls off the map
    function automatic int view_addr(int h, int v, int p1x, int p1y, int p2x, int p2y);
        int rel, wx, wy;
        rel = (h >= 320) ? h - 320 : h;
        wx = rel / 8 + ((h >= 320) ? p2x : p1x) - 20;
        wy = v / 8 + ((h >= 320) ? p2y : p1y) - 22;
        if (wx >= 320 || wy >= 240)
            return 0;
        return wy * 320 + wx;
    endfunction

    function automatic bit near_dot(int h, int v, int px, int py);
        int dx, dy;
        dx = (h - 240) * 2 - px;
        dy = (v - 360) * 2 - py;
        return dx >= -4 && dx <= 4 && dy >= -4 && dy <= 4;
    endfunction

    // --------------------
    // handshake
    // --------------------
    task automatic query_pixel(input string name, input int h, input int v, input int p1x,
                               input int p1y, input int p2x, input int p2y, input int hold,
                               output logic [11:0] colour, output int cycles);
        int expected_reads;
        expected_reads = (h >= 640 || v >= 480) ? 0 : 1;    // blank pixels skip the map
        cycles = 0;
        colour = '0;
        reads = 0;
        h_cnt = h;
        v_cnt = v;
        p1_x = p1x;
        p1_y = p1y;
        p2_x = p2x;
        p2_y = p2y;
        req = 1'b1;
        while (!ack && cycles < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ack) begin
            $display("%s: no ack within %0d cycles for pixel %0d,%0d", name, ACK_LIMIT, h, v);
            errors++;
        end else begin
            colour = {red, green, blue};
            if (cycles != 4) begin
                $display("error %s: cycles to ack expected 4, actual %0d", name, cycles);
                errors++;
            end
            repeat (hold) begin
                @(posedge clk);
                #1;
                if (!ack) begin
                    $display("%s: ack dropped while req was held", name);
                    errors++;
                end
                if ({red, green, blue} !== colour) begin
                    $display("error %s: held colour expected %h, actual %h",
                             name, colour, {red, green, blue});
                    errors++;
                end
            end
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        if (ack) begin
            $display("%s: ack still high one edge after req dropped", name);
            errors++;
        end
        repeat (2) @(posedge clk);    // engine back to idle
        #1;
        if (reads != expected_reads) begin
            $display("error %s: map reads expected %0d, actual %0d",
                     name, expected_reads, reads);
            errors++;
        end
    endtask

    task automatic check_pixel(input string name, input int h, input int v, input int p1x,
                               input int p1y, input int p2x, input int p2y,
                               input logic [11:0] expected);
        logic [11:0] colour;
        int          cycles;
        query_pixel(name, h, v, p1x, p1y, p2x, p2y, 0, colour, cycles);
        if (colour !== expected) begin
            $display("error %s: pixel %0d,%0d expected %h, actual %h",
                     name, h, v, expected, colour);
            errors++;
        end
    endtask

    // address of the last map read
    task automatic check_map_addr(input string name, input int expected);
        if (last_addr !== 17'(expected)) begin
            $display("error %s: map address expected %0d, actual %0d",
                     name, expected, last_addr);
            errors++;
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_reset_and_handshake();
        logic [11:0] colour;
        int          cycles;
        if (ack !== 1'b0 || map_rd !== 1'b0 || {red, green, blue} !== 12'h000) begin
            $display("error %s: expected ack 0 map_rd 0 colour 000, actual %b %b %h",
                     "test_reset_and_handshake", ack, map_rd, {red, green, blue});
            errors++;
        end
        query_pixel("test_reset_and_handshake", 100, 100, 100, 100, 300, 250, 10, colour, cycles);
        if (colour !== view_colour(100, 100, 100, 100, 300, 250)) begin
            $display("error test_reset_and_handshake: expected %h, actual %h",
                     view_colour(100, 100, 100, 100, 300, 250), colour);
            errors++;
        end
    endtask

    task automatic test_blank_and_separators();
        check_pixel("test_blank_and_separators", 640, 100, 100, 100, 300, 250, 12'h000);
        check_pixel("test_blank_and_separators", 700, 10, 100, 100, 300, 250, 12'h000);
        check_pixel("test_blank_and_separators", 100, 480, 100, 100, 300, 250, 12'h000);
        check_pixel("test_blank_and_separators", 1000, 1023, 100, 100, 300, 250, 12'h000);
        check_pixel("test_blank_and_separators", 100, 359, 100, 100, 300, 250, 12'hFFF);
        check_pixel("test_blank_and_separators", 500, 359, 100, 100, 300, 250, 12'hFFF);
        check_pixel("test_blank_and_separators", 100, 360, 100, 100, 300, 250, 12'hFFF);
        check_pixel("test_blank_and_separators", 300, 360, 100, 100, 300, 250, 12'hFFF);
        check_pixel("test_blank_and_separators", 319, 100, 100, 100, 300, 250, 12'hFFF);
        check_pixel("test_blank_and_separators", 320, 100, 100, 100, 300, 250, 12'hFFF);
    endtask

    task automatic test_map_view();
        int h, v, p1x, p1y, p2x, p2y;
        for (int i = 0; i < 40; i++) begin
            p1x = rand_range(20, 359);     // wide enough to leave the map now and then
            p1y = rand_range(22, 279);
            p2x = rand_range(20, 359);
            p2y = rand_range(22, 279);
            do begin
                h = (i % 2) ? rand_range(321, 639) : rand_range(0, 318);
                v = rand_range(0, 358);
            end while (in_car_box(h, v, p1x, p1y, p2x, p2y));
            check_pixel("test_map_view", h, v, p1x, p1y, p2x, p2y,
                        view_colour(h, v, p1x, p1y, p2x, p2y));
            check_map_addr("test_map_view", view_addr(h, v, p1x, p1y, p2x, p2y));
        end
    endtask

    task automatic test_car_boxes();
        check_pixel("test_car_boxes", 160, 180, 100, 100, 105, 103, 12'hF00);  // self left
        check_pixel("test_car_boxes", 450, 150, 100, 100, 105, 103, 12'h00F);  // self right
        check_pixel("test_car_boxes", 180, 200, 100, 100, 105, 103, 12'hF00);  // overlap
        check_pixel("test_car_boxes", 220, 230, 100, 100, 105, 103, 12'h00F);
        check_pixel("test_car_boxes", 420, 150, 196, 147, 200, 150, 12'hF00);  // enemy right
    endtask

    task automatic test_minimap_hud();
        int h, v, addr;
        check_pixel("test_minimap_hud", 290, 390, 100, 60, 200, 150, 12'hF00);
        check_pixel("test_minimap_hud", 340, 435, 100, 60, 200, 150, 12'h00F);
        for (int i = 0; i < 8; i++) begin
            do begin
                h = rand_range(240, 399);
                v = rand_range(361, 479);
            end while (near_dot(h, v, 100, 60) || near_dot(h, v, 200, 150));
            addr = ((v - 360) * 2) * 320 + (h - 240) * 2;
            check_pixel("test_minimap_hud", h, v, 100, 60, 200, 150, map_palette(addr % 6));
            check_map_addr("test_minimap_hud", addr);
        end
        check_pixel("test_minimap_hud", 100, 400, 100, 60, 200, 150, 12'h444);
        check_map_addr("test_minimap_hud", 0);
        check_pixel("test_minimap_hud", 239, 470, 100, 60, 200, 150, 12'h444);
        check_map_addr("test_minimap_hud", 0);
        check_pixel("test_minimap_hud", 400, 380, 100, 60, 200, 150, 12'h444);
        check_map_addr("test_minimap_hud", 0);
        check_pixel("test_minimap_hud", 600, 479, 100, 60, 200, 150, 12'h444);
        check_map_addr("test_minimap_hud", 0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        req = 1'b0;
        h_cnt = '0;
        v_cnt = '0;
        p1_x = '0;
        p1_y = '0;
        p2_x = '0;
        p2_y = '0;
        map_index = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_and_handshake();
        test_blank_and_separators();
        test_map_view();
        test_car_boxes();
        test_minimap_hud();
        $display("run complete, %0d errors counted", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
